//--- src/clint_pkg.sv
`default_nettype none

package clint_pkg;

  // ========================================
  // Bus encodings and address map
  // ========================================

  // Access size as carried on the request bus
  typedef enum logic [2:0] {
    SIZE_BYTE   = 3'd0,
    SIZE_HALF   = 3'd1,
    SIZE_WORD   = 3'd2,
    SIZE_DOUBLE = 3'd3
  } access_size_e;

  // Register region hit by a decoded offset
  typedef enum logic [1:0] {
    REGION_MSIP,
    REGION_MTIMECMP,
    REGION_MTIME,
    REGION_NONE
  } region_e;

  // Hart index pulled from the offset
  typedef logic [11:0] hart_idx_t;

  // Offsets inside the 64 KiB window
  localparam logic [15:0] MSIP_BASE     = 16'h0000;
  localparam logic [15:0] MTIMECMP_BASE = 16'h4000;
  localparam logic [15:0] MTIME_ADDR    = 16'hBFF8;

  // ========================================
  // Bus and write-broadcast structs
  // ========================================

  typedef struct packed {
    logic         valid;
    logic         we;
    access_size_e size;
    logic [15:0]  addr;
    logic [63:0]  wdata;
  } clint_req_t;

  typedef struct packed {
    logic        ready;
    logic [63:0] rdata;
  } clint_rsp_t;

  // Decoded write, data already sits in its byte lanes
  typedef struct packed {
    logic        strobe;
    region_e     region;
    hart_idx_t   hart;
    logic [7:0]  byte_mask;
    logic [63:0] data;
  } clint_wr_t;

  // ========================================
  // Byte-lane helpers
  // ========================================

  // Byte enables for a little-endian access of the given size
  function automatic logic [7:0] lane_mask(input access_size_e size, input logic [2:0] lo);
    logic [7:0] mask;
    case (size)
      SIZE_DOUBLE: mask = 8'hFF;
      // Upper or lower word by bit 2
      SIZE_WORD:   mask = lo[2] ? 8'hF0 : 8'h0F;
      // Lane pair picked by bits 2 and 1
      SIZE_HALF:   mask = 8'h03 << {lo[2:1], 1'b0};
      SIZE_BYTE:   mask = 8'h01 << lo;
      default:     mask = 8'h00;
    endcase
    return mask;
  endfunction

  // Replace the enabled bytes of old_val with those of new_val
  function automatic logic [63:0] lane_merge(input logic [63:0] old_val,
                                             input logic [63:0] new_val,
                                             input logic [7:0]  mask);
    logic [63:0] result;
    result = old_val;
    for (int b = 0; b < 8; b++) begin
      if (mask[b]) begin
        result[b*8 +: 8] = new_val[b*8 +: 8];
      end
    end
    return result;
  endfunction

endpackage

`default_nettype wire

//--- src/clint_bus_port.sv
`timescale 1ns/10ps
`default_nettype none

module clint_bus_port #(
  parameter int NUM_HARTS = 1
) (
  input  wire                  clk,
  input  wire                  reset_n,
  input  clint_pkg::clint_req_t req,
  input  wire  [63:0]          mtime,
  input  wire  [63:0]          cmp_rdata,
  input  wire                  msip_rdata,
  output clint_pkg::clint_wr_t  wr,
  output clint_pkg::hart_idx_t  rd_hart,
  output clint_pkg::clint_rsp_t rsp
);

  // ========================================
  // Offset decode
  // ========================================

  clint_pkg::region_e   region;
  clint_pkg::hart_idx_t hart;
  logic [15:0]          msip_off;
  logic [15:0]          cmp_off;
  logic [63:0]          rd_value;

  always_comb begin
    region   = clint_pkg::REGION_NONE;
    hart     = '0;
    // Byte offsets relative to each array base
    msip_off = req.addr - clint_pkg::MSIP_BASE;
    cmp_off  = req.addr - clint_pkg::MTIMECMP_BASE;
    // Shared counter owns the top aligned doubleword
    if (req.addr[15:3] == clint_pkg::MTIME_ADDR[15:3]) begin
      region = clint_pkg::REGION_MTIME;
    end else if (req.addr >= clint_pkg::MTIMECMP_BASE) begin
      // 8 bytes per hart
      region = clint_pkg::REGION_MTIMECMP;
      hart   = cmp_off[14:3];
    end else begin
      // 4 bytes per hart
      region = clint_pkg::REGION_MSIP;
      hart   = msip_off[13:2];
    end
    // Harts past the count fall into unmapped space
    if (region != clint_pkg::REGION_MTIME && int'(hart) >= NUM_HARTS) begin
      region = clint_pkg::REGION_NONE;
    end
  end

  // Register blocks read combinationally for the decoded hart
  assign rd_hart = hart;

  // ========================================
  // Write broadcast
  // ========================================

  always_comb begin
    wr.strobe    = req.valid && req.we && (region != clint_pkg::REGION_NONE);
    wr.region    = region;
    wr.hart      = hart;
    wr.byte_mask = clint_pkg::lane_mask(req.size, req.addr[2:0]);
    // Move low-order write data up to its byte lane
    wr.data      = req.wdata << {req.addr[2:0], 3'b000};
  end

  // ========================================
  // Read select and registered response
  // ========================================

  always_comb begin
    rd_value = 64'h0;
    // Writes and idle cycles return zero
    if (req.valid && !req.we) begin
      case (region)
        clint_pkg::REGION_MSIP:     rd_value = {63'h0, msip_rdata};
        clint_pkg::REGION_MTIMECMP: rd_value = cmp_rdata;
        clint_pkg::REGION_MTIME:    rd_value = mtime;
        default:                    rd_value = 64'h0;
      endcase
    end
  end

  // One-cycle response, no wait states
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rsp.ready <= 1'b0;
      rsp.rdata <= 64'h0;
    end else begin
      rsp.ready <= req.valid;
      rsp.rdata <= rd_value;
    end
  end

endmodule

`default_nettype wire

//--- src/mtime_counter.sv
`timescale 1ns/10ps
`default_nettype none

module mtime_counter #(
  parameter int MTIME_PRESCALER = 10
) (
  input  wire                  clk,
  input  wire                  reset_n,
  input  clint_pkg::clint_wr_t wr,
  output logic [63:0]          mtime
);

  // ========================================
  // Prescaler
  // ========================================

  // At least one bit even for a divide-by-one setting
  localparam int CNT_W = (MTIME_PRESCALER > 1) ? $clog2(MTIME_PRESCALER) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(MTIME_PRESCALER - 1);

  logic [CNT_W-1:0] pre_cnt;
  logic             mtime_wr;
  logic             tick;

  // Counter write from the bus
  assign mtime_wr = wr.strobe && (wr.region == clint_pkg::REGION_MTIME);

  // Last cycle of a prescaler period
  assign tick = (pre_cnt == CNT_LAST);

  // ========================================
  // Time counter
  // ========================================

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mtime   <= 64'h0;
      pre_cnt <= '0;
    end else if (mtime_wr) begin
      // Software load, restart the period
      mtime   <= clint_pkg::lane_merge(mtime, wr.data, wr.byte_mask);
      pre_cnt <= '0;
    end else if (tick) begin
      mtime   <= mtime + 64'h1;
      pre_cnt <= '0;
    end else begin
      pre_cnt <= pre_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- src/hart_timer_regs.sv
`timescale 1ns/10ps
`default_nettype none

module hart_timer_regs #(
  parameter int NUM_HARTS = 1
) (
  input  wire                  clk,
  input  wire                  reset_n,
  input  clint_pkg::clint_wr_t wr,
  input  clint_pkg::hart_idx_t rd_hart,
  input  wire  [63:0]          mtime,
  output logic [63:0]          cmp_rdata,
  output logic                 msip_rdata,
  output logic [NUM_HARTS-1:0] mti,
  output logic [NUM_HARTS-1:0] msi
);

  // ========================================
  // Per-hart state
  // ========================================

  logic [63:0]          mtimecmp [NUM_HARTS];
  logic [NUM_HARTS-1:0] msip;
  logic                 cmp_region;
  logic                 msip_region;

  // Region hits shared by every hart
  assign cmp_region  = wr.strobe && (wr.region == clint_pkg::REGION_MTIMECMP);
  assign msip_region = wr.strobe && (wr.region == clint_pkg::REGION_MSIP);

  genvar g;
  generate
    for (g = 0; g < NUM_HARTS; g++) begin : gen_hart
      // Odd harts sit in the upper word of the doubleword
      localparam int MSIP_LANE = (g % 2) * 4;

      logic cmp_hit;
      logic msip_hit;

      assign cmp_hit  = cmp_region && (int'(wr.hart) == g);
      // Low byte of the hart's own word carries the pending bit
      assign msip_hit = msip_region && (int'(wr.hart) == g) && wr.byte_mask[MSIP_LANE];

      // Compare register, all ones keeps the timer quiet
      always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
          mtimecmp[g] <= '1;
        end else if (cmp_hit) begin
          mtimecmp[g] <= clint_pkg::lane_merge(mtimecmp[g], wr.data, wr.byte_mask);
        end
      end

      // Software interrupt pending bit
      always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
          msip[g] <= 1'b0;
        end else if (msip_hit) begin
          msip[g] <= wr.data[MSIP_LANE*8];
        end
      end

      // Timer fires while time has reached the compare value
      assign mti[g] = (mtime >= mtimecmp[g]);
    end
  endgenerate

  assign msi = msip;

  // ========================================
  // Read selection
  // ========================================

  // Out-of-range index yields zero, the bus port masks it anyway
  always_comb begin
    cmp_rdata  = 64'h0;
    msip_rdata = 1'b0;
    for (int h = 0; h < NUM_HARTS; h++) begin
      if (int'(rd_hart) == h) begin
        cmp_rdata  = mtimecmp[h];
        msip_rdata = msip[h];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/clint_top.sv
`timescale 1ns/10ps
`default_nettype none

module clint_top #(
  parameter int NUM_HARTS       = 1,
  parameter int MTIME_PRESCALER = 10
) (
  input  wire                   clk,
  input  wire                   reset_n,
  input  clint_pkg::clint_req_t req,
  output clint_pkg::clint_rsp_t rsp,
  output logic [NUM_HARTS-1:0]  mti,
  output logic [NUM_HARTS-1:0]  msi
);

  // ========================================
  // Internal nets
  // ========================================

  // Decoded write, seen by both register blocks
  clint_pkg::clint_wr_t wr;
  clint_pkg::hart_idx_t rd_hart;
  logic [63:0]          mtime;
  logic [63:0]          cmp_rdata;
  logic                 msip_rdata;

  // Decode and response
  clint_bus_port #(
    .NUM_HARTS (NUM_HARTS)
  ) u_clint_bus_port (
    .clk        (clk),
    .reset_n    (reset_n),
    .req        (req),
    .mtime      (mtime),
    .cmp_rdata  (cmp_rdata),
    .msip_rdata (msip_rdata),
    .wr         (wr),
    .rd_hart    (rd_hart),
    .rsp        (rsp)
  );

  // Shared time base
  mtime_counter #(
    .MTIME_PRESCALER (MTIME_PRESCALER)
  ) u_mtime_counter (
    .clk     (clk),
    .reset_n (reset_n),
    .wr      (wr),
    .mtime   (mtime)
  );

  // Compare and software interrupt registers
  hart_timer_regs #(
    .NUM_HARTS (NUM_HARTS)
  ) u_hart_timer_regs (
    .clk        (clk),
    .reset_n    (reset_n),
    .wr         (wr),
    .rd_hart    (rd_hart),
    .mtime      (mtime),
    .cmp_rdata  (cmp_rdata),
    .msip_rdata (msip_rdata),
    .mti        (mti),
    .msi        (msi)
  );

endmodule

`default_nettype wire

//--- tests/clint_tb.sv
`timescale 1ns/10ps
`default_nettype none

module clint_tb;

  localparam int          NUM_HARTS = 2;
  localparam int          PRESCALE  = 4;
  localparam int          WAIT_MAX  = 16;
  localparam logic [15:0] CMP_OFF   = 16'h4000;
  localparam logic [15:0] MTIME_OFF = 16'hBFF8;
  // Unmapped offsets between and past the register ranges
  localparam logic [15:0] HOLES [5] = '{16'h0008, 16'h4010, 16'h0100, 16'h8000, 16'hBFF0};

  logic                  clk;
  logic                  reset_n;
  clint_pkg::clint_req_t req;
  clint_pkg::clint_rsp_t rsp;
  logic [NUM_HARTS-1:0]  mti;
  logic [NUM_HARTS-1:0]  msi;

  // Reference model state
  logic [63:0]          cmp_model [NUM_HARTS];
  logic [NUM_HARTS-1:0] msip_model;
  logic [63:0]          mt_val;
  int                   mt_edge;

  int          edge_cnt   = 0;
  logic        prev_valid = 1'b0;
  logic [31:0] lfsr;
  logic [63:0] exp_q [$];
  logic [63:0] exp_val;
  logic [63:0] last_rdata;
  int          errors;
  int          checks;
  int          tests;
  int          test_errors;

  clint_top #(
    .NUM_HARTS       (NUM_HARTS),
    .MTIME_PRESCALER (PRESCALE)
  ) u_clint_top (
    .clk     (clk),
    .reset_n (reset_n),
    .req     (req),
    .rsp     (rsp),
    .mti     (mti),
    .msi     (msi)
  );

  always #4 clk = ~clk;

  // Rising edges seen so far, read only on falling edges
  always @(posedge clk) edge_cnt <= edge_cnt + 1;

  // ========================================
  // Random source and compare tasks
  // ========================================

  // Galois LFSR, one step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[62:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return val;
  endfunction

  task automatic check_rdata(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_ready(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %0t %s expected %b got %b", $time, name, expected, actual);
    end
  endtask

  task automatic check_irq(input string name, input logic [NUM_HARTS-1:0] expected,
                           input logic [NUM_HARTS-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %0t %s expected %b got %b", $time, name, expected, actual);
    end
  endtask

  // ========================================
  // Reference model
  // ========================================

  // Lanes of a naturally aligned access of 2**size bytes
  function automatic logic [7:0] lanes_of(input clint_pkg::access_size_e size,
                                          input logic [2:0] lo);
    int nbytes;
    int first;
    nbytes = 1 << int'(size);
    first  = int'(lo) & ~(nbytes - 1);
    return 8'(((1 << nbytes) - 1) << first);
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_val,
                                              input clint_pkg::access_size_e size,
                                              input logic [15:0] addr,
                                              input logic [63:0] wdata);
    logic [7:0]  lanes;
    logic [63:0] placed;
    logic [63:0] result;
    lanes  = lanes_of(size, addr[2:0]);
    // Data moves up by the byte offset
    placed = wdata << (8 * int'(addr[2:0]));
    result = old_val;
    for (int b = 0; b < 8; b++) begin
      if (lanes[b]) begin
        result[b*8 +: 8] = placed[b*8 +: 8];
      end
    end
    return result;
  endfunction

  // Region and hart of an offset, out-of-range harts unmapped
  function automatic int decode(input logic [15:0] addr, output clint_pkg::region_e region);
    int hart;
    hart = 0;
    if (addr[15:3] == MTIME_OFF[15:3]) begin
      region = clint_pkg::REGION_MTIME;
    end else if (addr >= CMP_OFF) begin
      region = clint_pkg::REGION_MTIMECMP;
      hart   = int'(addr - CMP_OFF) / 8;
    end else begin
      region = clint_pkg::REGION_MSIP;
      hart   = int'(addr) / 4;
    end
    if (region != clint_pkg::REGION_MTIME && hart >= NUM_HARTS) begin
      region = clint_pkg::REGION_NONE;
    end
    return hart;
  endfunction

  // Counter value after the given rising edge
  function automatic logic [63:0] model_mtime(input int at_edge);
    return mt_val + 64'((at_edge - mt_edge) / PRESCALE);
  endfunction

  function automatic logic [NUM_HARTS-1:0] model_mti(input int at_edge);
    logic [NUM_HARTS-1:0] irq;
    for (int h = 0; h < NUM_HARTS; h++) begin
      irq[h] = (model_mtime(at_edge) >= cmp_model[h]);
    end
    return irq;
  endfunction

  function automatic logic [63:0] expected_read(input logic [15:0] addr, input int at_edge);
    clint_pkg::region_e region;
    int                 hart;
    logic [63:0]        value;
    hart  = decode(addr, region);
    value = 64'h0;
    case (region)
      clint_pkg::REGION_MSIP:     value = {63'h0, msip_model[hart]};
      clint_pkg::REGION_MTIMECMP: value = cmp_model[hart];
      clint_pkg::REGION_MTIME:    value = model_mtime(at_edge);
      default:                    value = 64'h0;
    endcase
    return value;
  endfunction

  // Write lands at the edge after at_edge
  task automatic apply_write(input clint_pkg::access_size_e size, input logic [15:0] addr,
                             input logic [63:0] wdata, input int at_edge);
    clint_pkg::region_e region;
    int                 hart;
    int                 lsb;
    logic [63:0]        merged;
    hart = decode(addr, region);
    case (region)
      clint_pkg::REGION_MSIP: begin
        // Odd harts own the upper word of the doubleword
        lsb    = (hart % 2) * 32;
        merged = merge_bytes(64'(msip_model[hart]) << lsb, size, addr, wdata);
        msip_model[hart] = merged[lsb];
      end
      clint_pkg::REGION_MTIMECMP: begin
        cmp_model[hart] = merge_bytes(cmp_model[hart], size, addr, wdata);
      end
      clint_pkg::REGION_MTIME: begin
        mt_val  = merge_bytes(model_mtime(at_edge), size, addr, wdata);
        mt_edge = at_edge + 1;
      end
      default: ;
    endcase
  endtask

  // ========================================
  // Bus driver and response checker
  // ========================================

  // One request, then wait until its response has been checked
  task automatic issue(input logic we, input clint_pkg::access_size_e size,
                       input logic [15:0] addr, input logic [63:0] wdata);
    int waited;
    exp_q.push_back(we ? 64'h0 : expected_read(addr, edge_cnt));
    if (we) begin
      apply_write(size, addr, wdata, edge_cnt);
    end
    req.valid = 1'b1;
    req.we    = we;
    req.size  = size;
    req.addr  = addr;
    req.wdata = wdata;
    @(negedge clk);
    req.valid = 1'b0;
    req.we    = 1'b0;
    waited    = 0;
    while (exp_q.size() != 0 && waited < WAIT_MAX) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("No response to the request at offset %h before the timeout", addr);
      exp_q.delete();
    end
  endtask

  // Sampled on the rising edge, before the response registers update
  always @(posedge clk) begin
    if (reset_n) begin
      check_ready("rsp.ready", prev_valid, rsp.ready);
      if (rsp.ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("A response arrived with no request outstanding at %0t", $time);
        end else begin
          exp_val = exp_q.pop_front();
          check_rdata("rsp.rdata", exp_val, rsp.rdata);
          last_rdata = rsp.rdata;
        end
      end
    end
    prev_valid = req.valid;
  end

  task automatic start_test();
    tests++;
    test_errors = errors;
  endtask

  task automatic finish_test(input string name);
    if (errors == test_errors) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - test_errors);
    end
  endtask

  // ========================================
  // Stimulus
  // ========================================

  initial begin
    logic [63:0]             v;
    logic [15:0]             addr;
    clint_pkg::access_size_e size;
    int                      hart;
    int                      lo;
    int                      n;
    clk         = 1'b0;
    reset_n     = 1'b0;
    req         = '0;
    lfsr        = 32'd95729;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    last_rdata  = 64'h0;
    msip_model  = '0;
    mt_val      = 64'h0;
    for (int h = 0; h < NUM_HARTS; h++) begin
      cmp_model[h] = '1;
    end
    repeat (3) @(negedge clk);
    reset_n = 1'b1;
    // Counter restarts from the last edge under reset
    mt_edge = edge_cnt;

    start_test();
    check_ready("rsp.ready", 1'b0, rsp.ready);
    check_irq("mti", '0, mti);
    check_irq("msi", '0, msi);
    issue(1'b0, clint_pkg::SIZE_DOUBLE, CMP_OFF, 64'h0);
    issue(1'b0, clint_pkg::SIZE_DOUBLE, CMP_OFF + 16'd8, 64'h0);
    issue(1'b0, clint_pkg::SIZE_WORD, 16'h0000, 64'h0);
    finish_test("reset state");

    start_test();
    for (int i = 0; i < 16; i++) begin
      hart = int'(rand_bits(1));
      size = clint_pkg::access_size_e'(rand_bits(2));
      // Offset aligned to the access size
      lo   = int'(rand_bits(3)) & ~((1 << int'(size)) - 1);
      addr = CMP_OFF + 16'(hart * 8 + lo);
      issue(1'b1, size, addr, rand_bits(64));
      issue(1'b0, clint_pkg::SIZE_DOUBLE, CMP_OFF + 16'(hart * 8), 64'h0);
    end
    finish_test("sized compare writes");

    start_test();
    issue(1'b1, clint_pkg::SIZE_DOUBLE, MTIME_OFF, rand_bits(64));
    for (int i = 0; i < 6; i++) begin
      n = int'(rand_bits(4));
      repeat (n) @(negedge clk);
      issue(1'b0, clint_pkg::SIZE_DOUBLE, MTIME_OFF, 64'h0);
    end
    // Half into lanes 2 and 3, then a single top byte
    issue(1'b1, clint_pkg::SIZE_HALF, MTIME_OFF + 16'd2, rand_bits(16));
    issue(1'b0, clint_pkg::SIZE_DOUBLE, MTIME_OFF, 64'h0);
    issue(1'b1, clint_pkg::SIZE_BYTE, MTIME_OFF + 16'd7, rand_bits(8));
    issue(1'b0, clint_pkg::SIZE_DOUBLE, MTIME_OFF, 64'h0);
    finish_test("time counter");

    start_test();
    v = rand_bits(48);
    issue(1'b1, clint_pkg::SIZE_DOUBLE, CMP_OFF, '1);
    issue(1'b1, clint_pkg::SIZE_DOUBLE, MTIME_OFF, v);
    issue(1'b1, clint_pkg::SIZE_DOUBLE, CMP_OFF + 16'd8, v + 64'd3);
    check_irq("mti", model_mti(edge_cnt), mti);
    n = 0;
    while (!mti[1] && n < 4 * WAIT_MAX) begin
      @(negedge clk);
      n++;
      check_irq("mti", model_mti(edge_cnt), mti);
    end
    if (!mti[1]) begin
      errors++;
      $display("Timer interrupt of hart 1 never rose");
    end
    issue(1'b0, clint_pkg::SIZE_DOUBLE, MTIME_OFF, 64'h0);
    if (last_rdata < v + 64'd3) begin
      errors++;
      $display("Time read after the timer interrupt is below the compare value");
    end
    finish_test("timer interrupt");

    start_test();
    for (int i = 0; i < 4; i++) begin
      // Hart 0 set, hart 1 set, hart 0 clear, hart 1 clear
      issue(1'b1, clint_pkg::SIZE_WORD, 16'((i % 2) * 4), 64'(i < 2));
      check_irq("msi", msip_model, msi);
    end
    issue(1'b1, clint_pkg::SIZE_WORD, 16'h0008, 64'h1);
    issue(1'b1, clint_pkg::SIZE_DOUBLE, CMP_OFF + 16'd16, 64'h0);
    check_irq("msi", msip_model, msi);
    check_irq("mti", model_mti(edge_cnt), mti);
    issue(1'b0, clint_pkg::SIZE_DOUBLE, CMP_OFF, 64'h0);
    issue(1'b0, clint_pkg::SIZE_DOUBLE, CMP_OFF + 16'd8, 64'h0);
    for (int i = 0; i < 5; i++) begin
      issue(1'b0, clint_pkg::SIZE_DOUBLE, HOLES[i], 64'h0);
    end
    finish_test("software interrupts and unmapped space");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
src/clint_pkg.sv
src/clint_bus_port.sv
src/mtime_counter.sv
src/hart_timer_regs.sv
src/clint_top.sv
tests/clint_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the CLINT testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps --top-module clint_tb \
  -Mdir "$OBJ_DIR" -f all.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/Vclint_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Fail message anywhere in the log means failure
if grep -q "Test failed" "$LOG"; then
  exit 1
fi
exit 0
